// ==== Makefile ====
# Verilator build and run for the pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_mc_core
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

FLIST   := flist.f
SRCS    := $(filter-out +incdir+%,$(shell cat $(FLIST)))
HEADERS := $(wildcard hw/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): $(FLIST) $(SRCS) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
+incdir+hw
hw/mc_pkg.sv
hw/mc_decoder.sv
hw/mc_regfile.sv
hw/mc_id_stage.sv
hw/mc_hazard_bypass.sv
hw/mc_ex_stage.sv
hw/mc_wb_stage.sv
hw/mc_core.sv
tests/tb_mc_core.sv

// ==== hw/mc_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mc_defines.svh"

module mc_core (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,

  // Instruction stream
  input  wire logic                 instr_valid_i,
  input  wire logic [`MC_XLEN-1:0]  instr_i,
  output logic                      instr_ready_o,

  // Data port
  output logic                      dmem_req_o,
  output logic [`MC_XLEN-1:0]       dmem_addr_o,
  input  wire logic                 dmem_rvalid_i,
  input  wire logic [`MC_XLEN-1:0]  dmem_rdata_i,

  // Retire port
  output logic                      wb_valid_o,
  output mc_pkg::rf_addr_t          wb_rd_o,
  output logic [`MC_XLEN-1:0]       wb_data_o
);
  import mc_pkg::*;

  // ID to controller
  logic                 id_valid;
  rf_addr_t             id_rs1;
  rf_addr_t             id_rs2;
  logic [1:0]           id_re;
  logic                 id_illegal;

  // ID to EX
  logic                 id_ex_valid;
  logic [`MC_XLEN-1:0]  id_ex_op_a;
  logic [`MC_XLEN-1:0]  id_ex_op_b;
  rf_addr_t             id_ex_rd;
  logic                 id_ex_we;
  logic                 id_ex_load;

  // EX state
  logic                 ex_valid;
  rf_addr_t             ex_rd;
  logic                 ex_we;
  logic                 ex_load;
  logic [`MC_XLEN-1:0]  ex_result;

  // WB state
  logic                 wb_stage_valid;
  logic                 wb_we;
  logic                 wb_ready;
  logic                 hold;

  // Controller outputs
  fw_sel_e              fw_a_sel;
  fw_sel_e              fw_b_sel;
  logic                 load_stall;
  logic                 deassert_we;

  // Waiting WB freezes the whole pipeline
  assign hold = !wb_ready;

  mc_id_stage i_id_stage (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .stall_i       (load_stall),
    .hold_i        (hold),
    .deassert_we_i (deassert_we),
    .fw_a_sel_i    (fw_a_sel),
    .fw_b_sel_i    (fw_b_sel),
    .ex_fw_data_i  (ex_result),
    .wb_fw_data_i  (wb_data_o),
    .wb_we_i       (wb_valid_o),
    .wb_rd_i       (wb_rd_o),
    .wb_wdata_i    (wb_data_o),
    .id_valid_o    (id_valid),
    .id_rs1_o      (id_rs1),
    .id_rs2_o      (id_rs2),
    .id_re_o       (id_re),
    .id_illegal_o  (id_illegal),
    .ex_valid_o    (id_ex_valid),
    .ex_op_a_o     (id_ex_op_a),
    .ex_op_b_o     (id_ex_op_b),
    .ex_rd_o       (id_ex_rd),
    .ex_we_o       (id_ex_we),
    .ex_load_o     (id_ex_load)
  );

  mc_hazard_bypass i_hazard_bypass (
    .rf_re_id_i    (id_re),
    .rs1_id_i      (id_rs1),
    .rs2_id_i      (id_rs2),
    .id_valid_i    (id_valid),
    .illegal_id_i  (id_illegal),
    .ex_valid_i    (ex_valid),
    .ex_we_i       (ex_we),
    .ex_load_i     (ex_load),
    .ex_rd_i       (ex_rd),
    .wb_valid_i    (wb_stage_valid),
    .wb_we_i       (wb_we),
    .wb_rd_i       (wb_rd_o),
    .wb_ready_i    (wb_ready),
    .fw_a_sel_o    (fw_a_sel),
    .fw_b_sel_o    (fw_b_sel),
    .load_stall_o  (load_stall),
    .deassert_we_o (deassert_we)
  );

  mc_ex_stage i_ex_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .hold_i      (hold),
    .in_valid_i  (id_ex_valid),
    .op_a_i      (id_ex_op_a),
    .op_b_i      (id_ex_op_b),
    .rd_i        (id_ex_rd),
    .we_i        (id_ex_we),
    .load_i      (id_ex_load),
    .ex_valid_o  (ex_valid),
    .ex_rd_o     (ex_rd),
    .ex_we_o     (ex_we),
    .ex_load_o   (ex_load),
    .ex_result_o (ex_result)
  );

  // Retire pulse drives the register file write and the retire port
  mc_wb_stage i_wb_stage (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .ex_valid_i    (ex_valid),
    .ex_rd_i       (ex_rd),
    .ex_we_i       (ex_we),
    .ex_load_i     (ex_load),
    .ex_result_i   (ex_result),
    .dmem_req_o    (dmem_req_o),
    .dmem_addr_o   (dmem_addr_o),
    .dmem_rvalid_i (dmem_rvalid_i),
    .dmem_rdata_i  (dmem_rdata_i),
    .wb_valid_o    (wb_stage_valid),
    .wb_rd_o       (wb_rd_o),
    .wb_we_o       (wb_we),
    .wb_ready_o    (wb_ready),
    .wb_data_o     (wb_data_o),
    .retire_o      (wb_valid_o)
  );

endmodule

`default_nettype wire

// ==== hw/mc_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mc_defines.svh"

module mc_decoder (
  input  wire mc_pkg::instr_u  instr_i,
  output logic [1:0]           rf_re_o,
  output mc_pkg::rf_addr_t     rs1_o,
  output mc_pkg::rf_addr_t     rs2_o,
  output mc_pkg::rf_addr_t     rd_o,
  output logic                 rf_we_o,
  output logic [`MC_XLEN-1:0]  imm_o,
  output logic                 use_imm_o,
  output logic                 load_o,
  output logic                 illegal_o
);
  import mc_pkg::*;

  // Register fields share their bit positions in both views
  assign rs1_o = instr_i.r.rs1;
  assign rs2_o = instr_i.r.rs2;
  assign rd_o  = instr_i.r.rd;

  // Sign extended I view immediate
  assign imm_o = {{(`MC_XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};

  // All three instructions write rd
  // Writes to x0 never leave ID
  // Illegal words are killed later by the hazard controller
  assign rf_we_o = |instr_i.r.rd;

  always_comb begin
    rf_re_o   = 2'b00;
    use_imm_o = 1'b0;
    load_o    = 1'b0;
    illegal_o = 1'b0;

    case (instr_i.r.opcode)
      OPC_OP: begin
        // ADD only, funct7 and funct3 must be zero
        if (instr_i.r.funct7 == 7'h00 && instr_i.r.funct3 == 3'b000) begin
          rf_re_o = 2'b11;
        end else begin
          illegal_o = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        // ADDI
        if (instr_i.i.funct3 == 3'b000) begin
          rf_re_o   = 2'b01;
          use_imm_o = 1'b1;
        end else begin
          illegal_o = 1'b1;
        end
      end
      OPC_LOAD: begin
        // LW only, address is rs1 plus imm12
        if (instr_i.i.funct3 == 3'b010) begin
          rf_re_o   = 2'b01;
          use_imm_o = 1'b1;
          load_o    = 1'b1;
        end else begin
          illegal_o = 1'b1;
        end
      end
      default: begin
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/mc_defines.svh ====
`ifndef MC_DEFINES_SVH
`define MC_DEFINES_SVH

// Datapath and instruction word width
`define MC_XLEN 32

// Register address width
`define MC_RF_AW 5

// Architectural registers reachable through MC_RF_AW
`define MC_RF_NUM (1 << `MC_RF_AW)

`endif

// ==== hw/mc_ex_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mc_defines.svh"

module mc_ex_stage (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 hold_i,

  // From ID
  input  wire logic                 in_valid_i,
  input  wire logic [`MC_XLEN-1:0]  op_a_i,
  input  wire logic [`MC_XLEN-1:0]  op_b_i,
  input  wire mc_pkg::rf_addr_t     rd_i,
  input  wire logic                 we_i,
  input  wire logic                 load_i,

  // To WB and the hazard controller
  output logic                      ex_valid_o,
  output mc_pkg::rf_addr_t          ex_rd_o,
  output logic                      ex_we_o,
  output logic                      ex_load_o,
  output logic [`MC_XLEN-1:0]       ex_result_o
);

  // Operand registers
  logic [`MC_XLEN-1:0] op_a_q;
  logic [`MC_XLEN-1:0] op_b_q;

  // ID/EX control
  // Frozen while WB back-pressures
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ex_valid_o <= 1'b0;
      ex_we_o    <= 1'b0;
      ex_load_o  <= 1'b0;
    end else if (!hold_i) begin
      ex_valid_o <= in_valid_i;
      ex_we_o    <= we_i;
      ex_load_o  <= load_i;
    end
  end

  // ID/EX payload
  always_ff @(posedge clk_i) begin
    if (!hold_i) begin
      ex_rd_o <= rd_i;
      op_a_q  <= op_a_i;
      op_b_q  <= op_b_i;
    end
  end

  // ADD and ADDI result, or LW address
  assign ex_result_o = op_a_q + op_b_q;

endmodule

`default_nettype wire

// ==== hw/mc_hazard_bypass.sv ====
`timescale 1ns/1ns
`default_nettype none

module mc_hazard_bypass (
  // From ID
  input  wire logic [1:0]        rf_re_id_i,
  input  wire mc_pkg::rf_addr_t  rs1_id_i,
  input  wire mc_pkg::rf_addr_t  rs2_id_i,
  input  wire logic              id_valid_i,
  input  wire logic              illegal_id_i,

  // From EX
  input  wire logic              ex_valid_i,
  input  wire logic              ex_we_i,
  input  wire logic              ex_load_i,
  input  wire mc_pkg::rf_addr_t  ex_rd_i,

  // From WB
  input  wire logic              wb_valid_i,
  input  wire logic              wb_we_i,
  input  wire mc_pkg::rf_addr_t  wb_rd_i,
  input  wire logic              wb_ready_i,

  // Controls back to ID
  output mc_pkg::fw_sel_e        fw_a_sel_o,
  output mc_pkg::fw_sel_e        fw_b_sel_o,
  output logic                   load_stall_o,
  output logic                   deassert_we_o
);
  import mc_pkg::*;

  // Read addresses indexed by port
  rf_addr_t    rs_id [2];

  // Qualified write enables of the older stages
  logic        rf_we_ex;
  logic        rf_we_wb;

  // Per read port RAW hazard against EX and WB
  logic [1:0]  ex_match;
  logic [1:0]  wb_match;

  assign rs_id[0] = rs1_id_i;
  assign rs_id[1] = rs2_id_i;

  assign rf_we_ex = ex_valid_i && ex_we_i;
  assign rf_we_wb = wb_valid_i && wb_we_i;

  // x0 never matches
  for (genvar i = 0; i < 2; i++) begin : gen_match
    assign ex_match[i] = rf_we_ex && rf_re_id_i[i] && |rs_id[i] && (ex_rd_i == rs_id[i]);
    assign wb_match[i] = rf_we_wb && rf_re_id_i[i] && |rs_id[i] && (wb_rd_i == rs_id[i]);
  end

  //////////////////////////////
  // Stall control
  //////////////////////////////

  // Load data is not ready while the load is in EX
  // or while WB still waits for rvalid
  assign load_stall_o = id_valid_i && ((ex_load_i && |ex_match) ||
                                       (!wb_ready_i && |wb_match));

  // Illegal word in ID writes nothing
  assign deassert_we_o = id_valid_i && illegal_id_i;

  //////////////////////////////
  // Forwarding select
  //////////////////////////////

  always_comb begin
    fw_a_sel_o = SEL_REGFILE;
    fw_b_sel_o = SEL_REGFILE;

    // WB result first
    if (wb_match[0]) begin
      fw_a_sel_o = SEL_FW_WB;
    end
    if (wb_match[1]) begin
      fw_b_sel_o = SEL_FW_WB;
    end

    // EX holds the younger value and overrides WB
    // Never taken for a load since ID stalls then
    if (ex_match[0]) begin
      fw_a_sel_o = SEL_FW_EX;
    end
    if (ex_match[1]) begin
      fw_b_sel_o = SEL_FW_EX;
    end
  end

endmodule

`default_nettype wire

// ==== hw/mc_id_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mc_defines.svh"

module mc_id_stage (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,

  // Instruction stream
  input  wire logic                 instr_valid_i,
  input  wire logic [`MC_XLEN-1:0]  instr_i,
  output logic                      instr_ready_o,

  // From the hazard controller and WB
  input  wire logic                 stall_i,
  input  wire logic                 hold_i,
  input  wire logic                 deassert_we_i,
  input  wire mc_pkg::fw_sel_e      fw_a_sel_i,
  input  wire mc_pkg::fw_sel_e      fw_b_sel_i,
  input  wire logic [`MC_XLEN-1:0]  ex_fw_data_i,
  input  wire logic [`MC_XLEN-1:0]  wb_fw_data_i,

  // Register file write from WB
  input  wire logic                 wb_we_i,
  input  wire mc_pkg::rf_addr_t     wb_rd_i,
  input  wire logic [`MC_XLEN-1:0]  wb_wdata_i,

  // To the hazard controller
  output logic                      id_valid_o,
  output mc_pkg::rf_addr_t          id_rs1_o,
  output mc_pkg::rf_addr_t          id_rs2_o,
  output logic [1:0]                id_re_o,
  output logic                      id_illegal_o,

  // To EX
  output logic                      ex_valid_o,
  output logic [`MC_XLEN-1:0]       ex_op_a_o,
  output logic [`MC_XLEN-1:0]       ex_op_b_o,
  output mc_pkg::rf_addr_t          ex_rd_o,
  output logic                      ex_we_o,
  output logic                      ex_load_o
);
  import mc_pkg::*;

  // IF/ID register
  logic                 id_valid_q;
  instr_u               id_instr_q;

  // Decoded fields
  logic [1:0]           dec_re;
  rf_addr_t             dec_rs1;
  rf_addr_t             dec_rs2;
  rf_addr_t             dec_rd;
  logic                 dec_we;
  logic [`MC_XLEN-1:0]  dec_imm;
  logic                 dec_use_imm;
  logic                 dec_load;
  logic                 dec_illegal;

  // Register file read data
  logic [`MC_XLEN-1:0]  rf_rdata_a;
  logic [`MC_XLEN-1:0]  rf_rdata_b;

  // Forwarding mux used for both operands
  function automatic logic [`MC_XLEN-1:0] fw_mux(
    input fw_sel_e             sel,
    input logic [`MC_XLEN-1:0] rf_val,
    input logic [`MC_XLEN-1:0] ex_val,
    input logic [`MC_XLEN-1:0] wb_val
  );
    logic [`MC_XLEN-1:0] res;
    case (sel)
      SEL_FW_EX: res = ex_val;
      SEL_FW_WB: res = wb_val;
      default:   res = rf_val;
    endcase
    return res;
  endfunction

  //////////////////////////////
  // IF/ID register
  //////////////////////////////

  // Stall is qualified with id_valid in the controller
  // so an empty ID accepts unless WB back-pressures
  assign instr_ready_o = !hold_i && !stall_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      id_valid_q <= 1'b0;
    end else if (instr_ready_o) begin
      id_valid_q <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i && instr_ready_o) begin
      id_instr_q <= instr_i;
    end
  end

  //////////////////////////////
  // Decode and operand read
  //////////////////////////////

  mc_decoder i_decoder (
    .instr_i   (id_instr_q),
    .rf_re_o   (dec_re),
    .rs1_o     (dec_rs1),
    .rs2_o     (dec_rs2),
    .rd_o      (dec_rd),
    .rf_we_o   (dec_we),
    .imm_o     (dec_imm),
    .use_imm_o (dec_use_imm),
    .load_o    (dec_load),
    .illegal_o (dec_illegal)
  );

  mc_regfile i_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (dec_rs1),
    .raddr_b_i (dec_rs2),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (wb_we_i),
    .waddr_i   (wb_rd_i),
    .wdata_i   (wb_wdata_i)
  );

  assign id_valid_o   = id_valid_q;
  assign id_rs1_o     = dec_rs1;
  assign id_rs2_o     = dec_rs2;
  assign id_re_o      = dec_re;
  assign id_illegal_o = dec_illegal;

  // Bubble into EX on load-use stall
  assign ex_valid_o = id_valid_q && !stall_i;

  // Operand B takes the immediate for ADDI and LW
  assign ex_op_a_o = fw_mux(fw_a_sel_i, rf_rdata_a, ex_fw_data_i, wb_fw_data_i);
  assign ex_op_b_o = dec_use_imm ? dec_imm
                                 : fw_mux(fw_b_sel_i, rf_rdata_b, ex_fw_data_i, wb_fw_data_i);

  assign ex_rd_o   = dec_rd;
  // Illegal word travels on as a nop
  assign ex_we_o   = dec_we && !deassert_we_i;
  assign ex_load_o = dec_load;

endmodule

`default_nettype wire

// ==== hw/mc_pkg.sv ====
`default_nettype none

`include "mc_defines.svh"

package mc_pkg;

  // Architectural register index
  typedef logic [`MC_RF_AW-1:0] rf_addr_t;

  // Operand source in front of EX
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // Major opcodes of the supported subset
  // ADD sits under OP, ADDI under OP_IMM, LW under LOAD
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OP_IMM = 7'h13,
    OPC_OP     = 7'h33
  } opcode_e;

  // Register-register layout
  typedef struct packed {
    logic [6:0]  funct7;
    rf_addr_t    rs2;
    rf_addr_t    rs1;
    logic [2:0]  funct3;
    rf_addr_t    rd;
    opcode_e     opcode;
  } instr_r_t;

  // Immediate layout
  // imm12 overlays funct7 and rs2 of the R view
  typedef struct packed {
    logic [11:0] imm12;
    rf_addr_t    rs1;
    logic [2:0]  funct3;
    rf_addr_t    rd;
    opcode_e     opcode;
  } instr_i_t;

  // One instruction word seen through both layouts
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

`default_nettype wire

// ==== hw/mc_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mc_defines.svh"

module mc_regfile (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire mc_pkg::rf_addr_t     raddr_a_i,
  input  wire mc_pkg::rf_addr_t     raddr_b_i,
  output logic [`MC_XLEN-1:0]       rdata_a_o,
  output logic [`MC_XLEN-1:0]       rdata_b_o,
  input  wire logic                 we_i,
  input  wire mc_pkg::rf_addr_t     waddr_i,
  input  wire logic [`MC_XLEN-1:0]  wdata_i
);

  // x1 to x31, x0 has no storage
  logic [`MC_XLEN-1:0] regs_q [1:`MC_RF_NUM-1];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < `MC_RF_NUM; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous read ports
  // x0 reads as zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== hw/mc_wb_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mc_defines.svh"

module mc_wb_stage (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,

  // From EX
  input  wire logic                 ex_valid_i,
  input  wire mc_pkg::rf_addr_t     ex_rd_i,
  input  wire logic                 ex_we_i,
  input  wire logic                 ex_load_i,
  input  wire logic [`MC_XLEN-1:0]  ex_result_i,

  // Data port
  output logic                      dmem_req_o,
  output logic [`MC_XLEN-1:0]       dmem_addr_o,
  input  wire logic                 dmem_rvalid_i,
  input  wire logic [`MC_XLEN-1:0]  dmem_rdata_i,

  // Stage state, forwarding and retire
  output logic                      wb_valid_o,
  output mc_pkg::rf_addr_t          wb_rd_o,
  output logic                      wb_we_o,
  output logic                      wb_ready_o,
  output logic [`MC_XLEN-1:0]       wb_data_o,
  output logic                      retire_o
);

  // EX/WB register
  logic                 wb_load_q;
  logic [`MC_XLEN-1:0]  wb_result_q;

  //////////////////////////////
  // Load request
  //////////////////////////////

  // Held with a stable address until rvalid
  assign dmem_req_o  = wb_valid_o && wb_load_q;
  assign dmem_addr_o = wb_result_q;

  // Stuck only by an outstanding load
  // rvalid without a request has no effect
  assign wb_ready_o = !dmem_req_o || dmem_rvalid_i;

  // Load data only counts in the rvalid cycle
  assign wb_data_o = wb_load_q ? dmem_rdata_i : wb_result_q;

  // One pulse per writing instruction
  assign retire_o = wb_valid_o && wb_we_o && wb_ready_o;

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_valid_o <= 1'b0;
      wb_we_o    <= 1'b0;
      wb_load_q  <= 1'b0;
    end else if (wb_ready_o) begin
      wb_valid_o <= ex_valid_i;
      wb_we_o    <= ex_we_i;
      wb_load_q  <= ex_load_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_ready_o) begin
      wb_rd_o     <= ex_rd_i;
      wb_result_q <= ex_result_i;
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_mc_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mc_defines.svh"

module tb_mc_core;

  // Instruction kinds known to the reference model
  localparam int OP_ADD  = 0;
  localparam int OP_ADDI = 1;
  localparam int OP_LW   = 2;

  localparam int N_DIRECTED = 25;
  localparam int N_RANDOM   = 80;
  localparam int N_INSTR    = N_DIRECTED + N_RANDOM;

  // Load data is the address with this pattern mixed in
  localparam logic [`MC_XLEN-1:0] LOAD_MIX = 32'h5A5A_0000;

  logic                 clk;
  logic                 rst_n_i;
  logic                 instr_valid_i;
  logic [`MC_XLEN-1:0]  instr_i;
  logic                 instr_ready_o;
  logic                 dmem_req_o;
  logic [`MC_XLEN-1:0]  dmem_addr_o;
  logic                 dmem_rvalid_i;
  logic [`MC_XLEN-1:0]  dmem_rdata_i;
  logic                 wb_valid_o;
  logic [4:0]           wb_rd_o;
  logic [`MC_XLEN-1:0]  wb_data_o;

  integer seed = 23;

  // Reference model state
  logic [`MC_XLEN-1:0]  model_rf [0:31];
  logic [4:0]           exp_rd_q [$];
  logic [`MC_XLEN-1:0]  exp_data_q [$];
  logic [`MC_XLEN-1:0]  exp_addr_q [$];

  // Checker and responder state
  logic [4:0]           exp_rd;
  logic [`MC_XLEN-1:0]  exp_data;
  logic [`MC_XLEN-1:0]  exp_addr;
  logic                 wait_prev;
  logic [`MC_XLEN-1:0]  addr_prev;
  logic                 resp_busy;
  logic [1:0]           resp_wait;
  logic [31:0]          resp_rnd;

  // Random stimulus fields
  logic [31:0]          stim_rnd;
  logic [4:0]           stim_rd;
  logic [4:0]           stim_rs1;
  logic [4:0]           stim_rs2;
  logic [11:0]          stim_imm;

  mc_core i_dut (
    .clk_i         (clk),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .dmem_req_o    (dmem_req_o),
    .dmem_addr_o   (dmem_addr_o),
    .dmem_rvalid_i (dmem_rvalid_i),
    .dmem_rdata_i  (dmem_rdata_i),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on a failed check");
  endtask

  // RISC-V R and I formats
  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // Hold the word on the falling edge until a rising edge sees ready
  task automatic send_word(input logic [31:0] word);
    @(negedge clk);
    instr_valid_i = 1'b1;
    instr_i       = word;
    @(posedge clk);
    while (!instr_ready_o) begin
      @(posedge clk);
    end
  endtask

  // Send one legal instruction, then run it on the model in program order
  task automatic issue_instr(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [11:0] imm);
    logic [31:0] word;
    logic [31:0] imm_x;
    logic [31:0] res;
    imm_x = {{20{imm[11]}}, imm};
    case (kind)
      OP_ADD:  word = rtype(7'h00, rs2, rs1, 3'b000, rd, 7'h33);
      OP_ADDI: word = itype(imm, rs1, 3'b000, rd, 7'h13);
      default: word = itype(imm, rs1, 3'b010, rd, 7'h03);
    endcase
    send_word(word);
    case (kind)
      OP_ADD:  res = model_rf[rs1] + model_rf[rs2];
      OP_ADDI: res = model_rf[rs1] + imm_x;
      default: begin
        exp_addr_q.push_back(model_rf[rs1] + imm_x);
        res = (model_rf[rs1] + imm_x) ^ LOAD_MIX;
      end
    endcase
    // x0 keeps zero and never retires
    if (rd != 5'd0) begin
      model_rf[rd] = res;
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(res);
    end
  endtask

  //////////////////////////////
  // Memory responder
  //////////////////////////////

  // 0 to 3 wait states per load, rvalid for one cycle
  always @(negedge clk) begin
    if (dmem_rvalid_i) begin
      dmem_rvalid_i = 1'b0;
      resp_busy     = 1'b0;
    end
    if (rst_n_i && dmem_req_o && !resp_busy) begin
      resp_busy = 1'b1;
      resp_rnd  = $random(seed);
      resp_wait = resp_rnd[1:0];
    end
    if (resp_busy) begin
      if (resp_wait == 2'd0) begin
        dmem_rvalid_i = 1'b1;
        dmem_rdata_i  = dmem_addr_o ^ LOAD_MIX;
      end else begin
        resp_wait = resp_wait - 2'd1;
      end
    end
  end

  //////////////////////////////
  // Checkers
  //////////////////////////////

  // Retire port against the model, in order
  always @(posedge clk) begin
    if (rst_n_i && wb_valid_o) begin
      assert (exp_rd_q.size() > 0) else fail_run("Retire pulse with no instruction left to retire");
      assert (wb_rd_o != 5'd0) else fail_run("Retire pulse for a write to x0");
      exp_rd   = exp_rd_q.pop_front();
      exp_data = exp_data_q.pop_front();
      assert (wb_rd_o == exp_rd)
        else fail_run($sformatf("ERROR @ %0t ns: wb_rd_o is x%0d, expected x%0d",
                                $time, wb_rd_o, exp_rd));
      assert (wb_data_o == exp_data)
        else fail_run($sformatf("ERROR @ %0t ns: x%0d retired %h, expected %h",
                                $time, wb_rd_o, wb_data_o, exp_data));
    end
  end

  // Data port handshake and back-pressure
  always @(posedge clk) begin
    if (!rst_n_i) begin
      wait_prev = 1'b0;
    end else begin
      if (wait_prev) begin
        assert (dmem_req_o) else fail_run("dmem_req_o dropped before dmem_rvalid_i");
        assert (dmem_addr_o == addr_prev)
          else fail_run($sformatf("ERROR @ %0t ns: dmem_addr_o moved to %h from %h",
                                  $time, dmem_addr_o, addr_prev));
      end else if (dmem_req_o) begin
        // First cycle of a new request
        assert (exp_addr_q.size() > 0) else fail_run("Load request with no load issued");
        exp_addr = exp_addr_q.pop_front();
        assert (dmem_addr_o == exp_addr)
          else fail_run($sformatf("ERROR @ %0t ns: dmem_addr_o is %h, expected %h",
                                  $time, dmem_addr_o, exp_addr));
      end
      if (dmem_req_o && !dmem_rvalid_i) begin
        assert (!wb_valid_o) else fail_run("Retire pulse while a load waits");
        assert (!instr_ready_o) else fail_run("instr_ready_o high while a load waits");
      end
      wait_prev = dmem_req_o && !dmem_rvalid_i;
      addr_prev = dmem_addr_o;
    end
  end

  // Watchdog
  initial begin
    repeat (N_INSTR * 8 + 50) @(posedge clk);
    $display("Timeout: the pipeline did not retire all instructions in time");
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    dmem_rvalid_i = 1'b0;
    dmem_rdata_i  = '0;
    resp_busy     = 1'b0;
    resp_wait     = 2'd0;
    wait_prev     = 1'b0;
    for (int r = 0; r < 32; r++) begin
      model_rf[r] = '0;
    end

    // Reset spans 16 rising edges
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;

    // Idle state right after reset
    @(posedge clk);
    assert (instr_ready_o) else fail_run("instr_ready_o low after reset");
    assert (!wb_valid_o) else fail_run("wb_valid_o high after reset");
    assert (!dmem_req_o) else fail_run("dmem_req_o high after reset");

    // Dependent ALU chain, x2 from EX and x1 from WB
    issue_instr(OP_ADDI, 5'd1, 5'd0, 5'd0, 12'd5);
    issue_instr(OP_ADDI, 5'd2, 5'd0, 5'd0, 12'hFFD);
    issue_instr(OP_ADD,  5'd3, 5'd1, 5'd2, 12'd0);
    issue_instr(OP_ADD,  5'd4, 5'd3, 5'd3, 12'd0);
    issue_instr(OP_ADDI, 5'd4, 5'd4, 5'd0, 12'd100);
    issue_instr(OP_ADD,  5'd5, 5'd4, 5'd1, 12'd0);

    // Load-use, load to load and load to ALU
    issue_instr(OP_LW,   5'd6, 5'd3, 5'd0, 12'd16);
    issue_instr(OP_ADD,  5'd7, 5'd6, 5'd6, 12'd0);
    issue_instr(OP_LW,   5'd8, 5'd7, 5'd0, 12'hFFC);
    issue_instr(OP_ADDI, 5'd8, 5'd8, 5'd0, 12'd1);
    issue_instr(OP_LW,   5'd9, 5'd8, 5'd0, 12'd0);
    issue_instr(OP_LW,   5'd10, 5'd9, 5'd0, 12'd8);
    issue_instr(OP_ADD,  5'd11, 5'd10, 5'd9, 12'd0);

    // x0 as a destination and as a source
    issue_instr(OP_ADDI, 5'd0, 5'd1, 5'd0, 12'd7);
    issue_instr(OP_ADD,  5'd12, 5'd0, 5'd1, 12'd0);
    issue_instr(OP_ADD,  5'd0, 5'd12, 5'd12, 12'd0);
    issue_instr(OP_ADD,  5'd13, 5'd0, 5'd0, 12'd0);

    // Illegal words, the model skips them
    // SUB
    send_word(rtype(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, 7'h33));
    issue_instr(OP_ADD,  5'd14, 5'd3, 5'd1, 12'd0);
    // Unknown opcode
    send_word(itype(12'h000, 5'd0, 3'b000, 5'd5, 7'h7F));
    issue_instr(OP_ADDI, 5'd15, 5'd5, 5'd0, 12'd1);
    // SLLI
    send_word(itype(12'h001, 5'd1, 3'b001, 5'd1, 7'h13));
    issue_instr(OP_ADD,  5'd16, 5'd1, 5'd1, 12'd0);
    // LB
    send_word(itype(12'h004, 5'd3, 3'b000, 5'd2, 7'h03));
    issue_instr(OP_ADD,  5'd17, 5'd2, 5'd2, 12'd0);

    // Random mix on x0 to x7 for dense hazards
    for (int n = 0; n < N_RANDOM; n++) begin
      stim_rnd = $random(seed);
      stim_rd  = {2'b00, stim_rnd[2:0]};
      stim_rs1 = {2'b00, stim_rnd[5:3]};
      stim_rs2 = {2'b00, stim_rnd[8:6]};
      stim_imm = stim_rnd[20:9];
      case (stim_rnd[23:21])
        3'd0, 3'd1, 3'd2: issue_instr(OP_ADD, stim_rd, stim_rs1, stim_rs2, 12'd0);
        3'd3, 3'd4:       issue_instr(OP_ADDI, stim_rd, stim_rs1, 5'd0, stim_imm);
        3'd5, 3'd6:       issue_instr(OP_LW, stim_rd, stim_rs1, 5'd0, stim_imm);
        default:          send_word(rtype(7'h20, stim_rs2, stim_rs1, 3'b000, stim_rd, 7'h33));
      endcase
      // Occasional gap with a junk word on the bus
      if (stim_rnd[31:29] == 3'b000) begin
        @(negedge clk);
        instr_valid_i = 1'b0;
        instr_i       = stim_rnd;
      end
    end

    @(negedge clk);
    instr_valid_i = 1'b0;

    // Drain, then give stray retires a chance to show
    while (exp_rd_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (10) @(posedge clk);
    assert (exp_addr_q.size() == 0) else fail_run("A load never requested its data");

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire
